/* mint.sv */
module mint
(
    input  logic            i_clk,          // unused, port kept for compatibility
    input  logic            i_start,        // unused as well
    input  logic            i_op1_signed,
    input  logic            i_op2_signed,
    input  mint_pkg::word_t i_op1,
    input  mint_pkg::word_t i_op2,
    output mint_pkg::word_t o_div,
    output logic [63:0]     o_mul,
    output mint_pkg::word_t o_rem
);

    logic            op1_neg;
    logic            op2_neg;
    mint_pkg::word_t op1_mag;
    mint_pkg::word_t op2_mag;
    mint_pkg::word_t quo_mag;
    mint_pkg::word_t rem_mag;

    // a negative operand only counts when it is declared signed
    assign op1_neg = i_op1_signed & i_op1[31];
    assign op2_neg = i_op2_signed & i_op2[31];

    assign op1_mag = op1_neg ? (~i_op1 + 32'd1) : i_op1;
    assign op2_mag = op2_neg ? (~i_op2 + 32'd1) : i_op2;

    // unsigned divide on magnitudes
    // zero divisor gives no defined value here, the result stage overrides it
    assign quo_mag = op1_mag / op2_mag;
    assign rem_mag = op1_mag % op2_mag;

    assign o_div = (op1_neg ^ op2_neg) ? (~quo_mag + 32'd1) : quo_mag;
    assign o_rem = op1_neg ? (~rem_mag + 32'd1) : rem_mag;     // sign of the dividend

    // multiplicand as a 33-bit value, sign extended to the full width
    logic [63:0] mcand;
    logic [63:0] acc [0:32];

    assign mcand  = {{32{op1_neg}}, i_op1};
    assign acc[0] = '0;

    // one shifted row per multiplier bit, summed as a chain
    for (genvar i = 0; i < 32; i++)
    begin : g_row
        assign acc[i+1] = acc[i] + (i_op2[i] ? (mcand << i) : 64'd0);
    end

    // sign correction
    // in the 33-bit view of op2 the top bit weighs -2^32
    assign o_mul = acc[32] - (op2_neg ? {mcand[31:0], 32'd0} : 64'd0);

endmodule

/* mint_issue.sv */
module mint_issue
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_req_valid,
    input  mint_pkg::op_t   i_req_op,
    input  mint_pkg::word_t i_req_op1,
    input  mint_pkg::word_t i_req_op2,
    input  mint_pkg::tag_t  i_req_tag,
    mint_stage_if.source    o_stage
);

    logic           op1_signed;
    logic           op2_signed;
    mint_pkg::sel_t sel;

    // mulhsu treats only op1 as signed
    assign op1_signed = (i_req_op == mint_pkg::OP_MULH) || (i_req_op == mint_pkg::OP_MULHSU) ||
                        (i_req_op == mint_pkg::OP_DIV)  || (i_req_op == mint_pkg::OP_REM);
    assign op2_signed = (i_req_op == mint_pkg::OP_MULH) || (i_req_op == mint_pkg::OP_DIV) ||
                        (i_req_op == mint_pkg::OP_REM);

    always_comb
    begin
        case (i_req_op)
            mint_pkg::OP_MUL:  sel = mint_pkg::SEL_LO;
            mint_pkg::OP_DIV,
            mint_pkg::OP_DIVU: sel = mint_pkg::SEL_QUO;
            mint_pkg::OP_REM,
            mint_pkg::OP_REMU: sel = mint_pkg::SEL_REM;
            default:           sel = mint_pkg::SEL_HI;     // the mulh forms
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_stage.valid <= 1'b0;
        else
            o_stage.valid <= i_req_valid;
    end

    // payload follows the input every cycle
    always_ff @(posedge i_clk)
    begin
        o_stage.op1        <= i_req_op1;
        o_stage.op2        <= i_req_op2;
        o_stage.op1_signed <= op1_signed;
        o_stage.op2_signed <= op2_signed;
        o_stage.sel        <= sel;
        o_stage.tag        <= i_req_tag;
    end

    // requester must present clean fields with every request
    a_req_known: assert property (@(posedge i_clk) disable iff (i_rst)
        i_req_valid |-> !$isunknown({i_req_op, i_req_op1, i_req_op2, i_req_tag}))
        else $error("request with unknown bits in op, operands or tag");

endmodule

/* mint_pkg.sv */
package mint_pkg;

    // operand and result word
    typedef logic [31:0] word_t;

    // operation code in funct3 order
    typedef logic [2:0] op_t;

    localparam op_t OP_MUL    = 3'd0;
    localparam op_t OP_MULH   = 3'd1;
    localparam op_t OP_MULHSU = 3'd2;
    localparam op_t OP_MULHU  = 3'd3;
    localparam op_t OP_DIV    = 3'd4;
    localparam op_t OP_DIVU   = 3'd5;
    localparam op_t OP_REM    = 3'd6;
    localparam op_t OP_REMU   = 3'd7;

    // request tag, echoed back with the response
    typedef logic [3:0] tag_t;

    // which part of the arithmetic result goes out
    typedef logic [1:0] sel_t;

    localparam sel_t SEL_LO  = 2'd0;    // product bits 31:0
    localparam sel_t SEL_HI  = 2'd1;    // product bits 63:32
    localparam sel_t SEL_QUO = 2'd2;
    localparam sel_t SEL_REM = 2'd3;

endpackage

/* mint_result.sv */
module mint_result
(
    input  logic            i_clk,
    input  logic            i_rst,
    mint_stage_if.sink      i_stage,
    input  mint_pkg::word_t i_div,
    input  logic [63:0]     i_mul,
    input  mint_pkg::word_t i_rem,
    mint_stage_if.source    o_stage
);

    logic            div_zero;
    logic            div_ovf;
    mint_pkg::word_t result;

    assign div_zero = (i_stage.op2 == '0);

    // most negative over minus one, only for the signed forms
    assign div_ovf = i_stage.op1_signed & i_stage.op2_signed &
                     (i_stage.op1 == 32'h8000_0000) & (i_stage.op2 == '1);

    // remainder sign already follows the dividend out of mint
    always_comb
    begin
        case (i_stage.sel)
            mint_pkg::SEL_HI:
                result = i_mul[63:32];
            mint_pkg::SEL_QUO:
            begin
                if (div_zero)
                    result = '1;
                else if (div_ovf)
                    result = i_stage.op1;
                else
                    result = i_div;
            end
            mint_pkg::SEL_REM:
            begin
                if (div_zero)
                    result = i_stage.op1;               // dividend passes through
                else if (div_ovf)
                    result = '0;
                else
                    result = i_rem;
            end
            default:
                result = i_mul[31:0];
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_stage.valid <= 1'b0;
        else
            o_stage.valid <= i_stage.valid;
    end

    always_ff @(posedge i_clk)
    begin
        o_stage.op1 <= result;
        o_stage.tag <= i_stage.tag;
    end

    // only op1 and tag travel on to the queue
    assign o_stage.op2        = '0;
    assign o_stage.op1_signed = 1'b0;
    assign o_stage.op2_signed = 1'b0;
    assign o_stage.sel        = mint_pkg::SEL_LO;

    a_result_known: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stage.valid |-> !$isunknown({o_stage.op1, o_stage.tag}))
        else $error("registered result has unknown bits");

endmodule

/* mint_rsp_queue.sv */
module mint_rsp_queue
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int RSP_CREDITS = 2
)
(
    input  logic            i_clk,
    input  logic            i_rst,
    mint_stage_if.sink      i_stage,
    input  logic            i_rsp_credit,
    output logic            o_req_credit,
    output logic            o_rsp_valid,
    output mint_pkg::word_t o_rsp_data,
    output mint_pkg::tag_t  o_rsp_tag
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(RSP_CREDITS + 1);

    mint_pkg::word_t  mem_data [QUEUE_DEPTH];
    mint_pkg::tag_t   mem_tag  [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // entries held in the buffer
    logic [CRD_W-1:0] credits;      // response credits on hand
    logic             pop;

    // wraps for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    assign pop = (count != '0) && (credits != '0);

    assign o_rsp_valid  = pop;
    assign o_req_credit = pop;      // the entry is free once it leaves
    assign o_rsp_data   = mem_data[rd_ptr];
    assign o_rsp_tag    = mem_tag[rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (i_stage.valid)
        begin
            mem_data[wr_ptr] <= i_stage.op1;
            mem_tag[wr_ptr]  <= i_stage.tag;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(RSP_CREDITS);
        end
        else
        begin
            if (i_stage.valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            count   <= count + CNT_W'(i_stage.valid) - CNT_W'(pop);
            credits <= credits + CRD_W'(i_rsp_credit) - CRD_W'(pop);
        end
    end

    // requester credits cover the pipeline, so a write always finds room
    a_no_full_write: assert property (@(posedge i_clk) disable iff (i_rst)
        i_stage.valid |-> (count < QUEUE_DEPTH))
        else $error("write into a full response queue");

    a_credit_max: assert property (@(posedge i_clk) disable iff (i_rst)
        credits <= RSP_CREDITS)
        else $error("more response credits returned than were issued");

    // head entry must have been written before it leaves
    a_rsp_known: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rsp_valid |-> !$isunknown({o_rsp_data, o_rsp_tag}))
        else $error("response leaves with unknown data or tag");

endmodule

/* mint_stage_if.sv */
interface mint_stage_if;

    logic            valid;
    mint_pkg::word_t op1;
    mint_pkg::word_t op2;          // divisor for div and rem
    logic            op1_signed;
    logic            op2_signed;
    mint_pkg::sel_t  sel;
    mint_pkg::tag_t  tag;

    // no ready, space is guaranteed by the request credits
    modport source
    (
        output valid, op1, op2, op1_signed, op2_signed, sel, tag
    );

    modport sink
    (
        input valid, op1, op2, op1_signed, op2_signed, sel, tag
    );

endinterface

/* mint_unit.f */
mint_pkg.sv
mint_stage_if.sv
mint_issue.sv
mint.sv
mint_result.sv
mint_rsp_queue.sv
mint_unit.sv
tb_clk_gen.sv
tb_mint_unit.sv

/* mint_unit.sv */
module mint_unit
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int RSP_CREDITS = 2
)
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_req_valid,
    input  mint_pkg::op_t   i_req_op,
    input  mint_pkg::word_t i_req_op1,
    input  mint_pkg::word_t i_req_op2,
    input  mint_pkg::tag_t  i_req_tag,
    input  logic            i_rsp_credit,
    output logic            o_req_credit,
    output logic            o_rsp_valid,
    output mint_pkg::word_t o_rsp_data,
    output mint_pkg::tag_t  o_rsp_tag
);

    mint_pkg::word_t div;
    logic [63:0]     mul;
    mint_pkg::word_t rem;

    mint_stage_if issue_s ();
    mint_stage_if result_s ();

    mint_issue issue_i
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .i_req_op    (i_req_op),
        .i_req_op1   (i_req_op1),
        .i_req_op2   (i_req_op2),
        .i_req_tag   (i_req_tag),
        .o_stage     (issue_s)
    );

    // arithmetic works on the issue stage operands
    mint mint_i
    (
        .i_clk        (i_clk),
        .i_start      (issue_s.valid),
        .i_op1_signed (issue_s.op1_signed),
        .i_op2_signed (issue_s.op2_signed),
        .i_op1        (issue_s.op1),
        .i_op2        (issue_s.op2),
        .o_div        (div),
        .o_mul        (mul),
        .o_rem        (rem)
    );

    mint_result result_i
    (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stage (issue_s),
        .i_div   (div),
        .i_mul   (mul),
        .i_rem   (rem),
        .o_stage (result_s)
    );

    mint_rsp_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) queue_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stage      (result_s),
        .i_rsp_credit (i_rsp_credit),
        .o_req_credit (o_req_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_data   (o_rsp_data),
        .o_rsp_tag    (o_rsp_tag)
    );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen
(
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;      // 4 ns period
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (4) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

/* tb_mint_unit.sv */
module tb_mint_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int QUEUE_DEPTH = 4;
    localparam int RSP_CREDITS = 2;
    localparam int TIMEOUT     = 200;   // cycles allowed per wait
    localparam int N_VEC       = 25;
    localparam int N_BURST     = 16;

    typedef struct {
        string           name;
        mint_pkg::op_t   op;
        mint_pkg::word_t op1;
        mint_pkg::word_t op2;
        mint_pkg::word_t exp;
    } vec_t;

    // sign extremes, truncation cases, zero divisor and overflow
    vec_t vectors [N_VEC] = '{
        '{"mul_small",   mint_pkg::OP_MUL,    32'd7,        32'd6,        32'h0000_002a},
        '{"mul_neg",     mint_pkg::OP_MUL,    32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001},
        '{"mul_zero",    mint_pkg::OP_MUL,    32'd0,        32'h8000_0000, 32'h0000_0000},
        '{"mulh_neg",    mint_pkg::OP_MULH,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000},
        '{"mulh_min",    mint_pkg::OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000},
        '{"mulh_max",    mint_pkg::OP_MULH,   32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff},
        '{"mulh_minmax", mint_pkg::OP_MULH,   32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000},
        '{"mulh_one",    mint_pkg::OP_MULH,   32'd1,        32'hffff_ffff, 32'hffff_ffff},
        '{"mulhsu_neg",  mint_pkg::OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff},
        '{"mulhsu_min",  mint_pkg::OP_MULHSU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000},
        '{"mulhu_max",   mint_pkg::OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe},
        '{"mulhu_carry", mint_pkg::OP_MULHU,  32'h8000_0000, 32'd2,        32'h0000_0001},
        '{"div_pos",     mint_pkg::OP_DIV,    32'd20,       32'd3,        32'h0000_0006},
        '{"div_neg_num", mint_pkg::OP_DIV,    32'hffff_ffec, 32'd3,        32'hffff_fffa},
        '{"div_neg_den", mint_pkg::OP_DIV,    32'd20,       32'hffff_fffd, 32'hffff_fffa},
        '{"divu_big",    mint_pkg::OP_DIVU,   32'hffff_ffec, 32'd3,        32'h5555_554e},
        '{"rem_neg_num", mint_pkg::OP_REM,    32'hffff_ffec, 32'd3,        32'hffff_fffe},
        '{"rem_neg_den", mint_pkg::OP_REM,    32'd20,       32'hffff_fffd, 32'h0000_0002},
        '{"remu_big",    mint_pkg::OP_REMU,   32'hffff_ffec, 32'd3,        32'h0000_0002},
        '{"div_zero",    mint_pkg::OP_DIV,    32'h0000_1234, 32'd0,        32'hffff_ffff},
        '{"divu_zero",   mint_pkg::OP_DIVU,   32'h0000_1234, 32'd0,        32'hffff_ffff},
        '{"rem_zero",    mint_pkg::OP_REM,    32'h8000_0001, 32'd0,        32'h8000_0001},
        '{"remu_zero",   mint_pkg::OP_REMU,   32'd5,        32'd0,        32'h0000_0005},
        '{"div_ovf",     mint_pkg::OP_DIV,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000},
        '{"rem_ovf",     mint_pkg::OP_REM,    32'h8000_0000, 32'hffff_ffff, 32'h0000_0000}
    };

    logic            clk;
    logic            rst;
    logic            req_valid;
    mint_pkg::op_t   req_op;
    mint_pkg::word_t req_op1;
    mint_pkg::word_t req_op2;
    mint_pkg::tag_t  req_tag;
    logic            rsp_credit = 1'b0;
    logic            req_credit;
    logic            rsp_valid;
    mint_pkg::word_t rsp_data;
    mint_pkg::tag_t  rsp_tag;

    string           exp_name [$];
    mint_pkg::word_t exp_data [$];
    mint_pkg::tag_t  exp_tag  [$];

    int seed          = 32'h1f1c_c4c4;
    int req_credits   = QUEUE_DEPTH;    // requester side credit count
    int owed          = 0;              // response credits not yet handed back
    int rsp_count     = 0;
    int credit_pulses = 0;
    int sent          = 0;
    int tests         = 0;
    int errors        = 0;
    bit hold_credits  = 1'b0;
    bit timed_out     = 1'b0;

    tb_clk_gen clk_gen_i
    (
        .o_clk (clk),
        .o_rst (rst)
    );

    mint_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RSP_CREDITS (RSP_CREDITS)
    ) dut_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_req_valid  (req_valid),
        .i_req_op     (req_op),
        .i_req_op1    (req_op1),
        .i_req_op2    (req_op2),
        .i_req_tag    (req_tag),
        .i_rsp_credit (rsp_credit),
        .o_req_credit (req_credit),
        .o_rsp_valid  (rsp_valid),
        .o_rsp_data   (rsp_data),
        .o_rsp_tag    (rsp_tag)
    );

    // M-extension rules on 64-bit integers
    function automatic mint_pkg::word_t ref_result(input mint_pkg::op_t op,
                                                   input mint_pkg::word_t a,
                                                   input mint_pkg::word_t b);
        longint          sa;
        longint          sb;
        logic [63:0]     ua;
        logic [63:0]     ub;
        logic            ovf;
        mint_pkg::word_t res;
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        ua  = {32'd0, a};
        ub  = {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            mint_pkg::OP_MUL:    res = 32'(ua * ub);
            mint_pkg::OP_MULH:   res = 32'((sa * sb) >>> 32);
            mint_pkg::OP_MULHSU: res = 32'((sa * longint'(ub)) >>> 32);
            mint_pkg::OP_MULHU:  res = 32'((ua * ub) >> 32);
            mint_pkg::OP_DIV:    res = (b == 0) ? 32'hffff_ffff : (ovf ? a : 32'(sa / sb));
            mint_pkg::OP_DIVU:   res = (b == 0) ? 32'hffff_ffff : a / b;
            mint_pkg::OP_REM:    res = (b == 0) ? a : (ovf ? 32'd0 : 32'(sa % sb));
            default:             res = (b == 0) ? a : a % b;
        endcase
        return res;
    endfunction

    task automatic check_word(input string name, input mint_pkg::word_t exp,
                              input mint_pkg::word_t act, output bit ok);
        ok = (act === exp);
        if (!ok)
            $display("** Error %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic check_tag(input string name, input mint_pkg::tag_t exp,
                             input mint_pkg::tag_t act, output bit ok);
        ok = (act === exp);
        if (!ok)
            $display("** Error %s: expected tag %0d, actual tag %0d", name, exp, act);
    endtask

    task automatic send_req(input string name, input mint_pkg::op_t op,
                            input mint_pkg::word_t a, input mint_pkg::word_t b,
                            input mint_pkg::tag_t tag, input mint_pkg::word_t exp);
        int waited;
        waited = 0;
        while (!timed_out && req_credits == 0)
        begin
            @(posedge clk);
            req_valid <= 1'b0;      // no credit, no request
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("timeout: no request credit came back before %s", name);
                errors++;
                timed_out = 1'b1;
            end
        end
        if (!timed_out)
        begin
            @(posedge clk);
            req_valid <= 1'b1;
            req_op    <= op;
            req_op1   <= a;
            req_op2   <= b;
            req_tag   <= tag;
            req_credits--;
            sent++;
            exp_name.push_back(name);
            exp_data.push_back(exp);
            exp_tag.push_back(tag);
        end
    endtask

    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b0;
        while (!timed_out && exp_data.size() != 0)
        begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("timeout: %s still had %0d responses missing", what, exp_data.size());
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // response checker, sampled mid-cycle
    always @(negedge clk)
    begin
        bit              ok_data;
        bit              ok_tag;
        string           name;
        mint_pkg::word_t e_data;
        mint_pkg::tag_t  e_tag;
        if (!rst && rsp_valid)
        begin
            owed++;
            rsp_count++;
            if (exp_data.size() == 0)
            begin
                $display("response with tag %0d arrived when none was expected", rsp_tag);
                errors++;
            end
            else
            begin
                name   = exp_name.pop_front();
                e_data = exp_data.pop_front();
                e_tag  = exp_tag.pop_front();
                check_word(name, e_data, rsp_data, ok_data);
                check_tag(name, e_tag, rsp_tag, ok_tag);
                tests++;
                if (ok_data && ok_tag)
                    $display("%-12s ok", name);
                else
                begin
                    errors++;
                    $display("%-12s failed", name);
                end
            end
        end
        if (!rst && req_credit)
        begin
            req_credits++;
            credit_pulses++;
        end
    end

    // hands response credits back one per cycle unless held
    always @(posedge clk)
    begin
        if (!hold_credits && owed > 0)
        begin
            rsp_credit <= 1'b1;
            owed--;
        end
        else
            rsp_credit <= 1'b0;
    end

    initial
    begin
        int              waited;
        int              base_rsp;
        int              base_pulse;
        int              base_sent;
        bit              idle_ok;
        mint_pkg::op_t   op;
        mint_pkg::word_t a;
        mint_pkg::word_t b;
        req_valid <= 1'b0;
        req_op    <= '0;
        req_op1   <= '0;
        req_op2   <= '0;
        req_tag   <= '0;
        waited = 0;
        while (!timed_out && rst !== 1'b0)
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("timeout: reset was never released");
                errors++;
                timed_out = 1'b1;
            end
        end

        // quiet outputs before the first request
        idle_ok = 1'b1;
        repeat (8)
        begin
            @(negedge clk);
            if (rsp_valid !== 1'b0 || req_credit !== 1'b0)
                idle_ok = 1'b0;
        end
        tests++;
        if (idle_ok)
            $display("idle_after_reset ok");
        else
        begin
            errors++;
            $display("idle_after_reset failed, response or credit seen with no request sent");
        end

        for (int i = 0; i < N_VEC; i++)
            send_req(vectors[i].name, vectors[i].op, vectors[i].op1, vectors[i].op2,
                     mint_pkg::tag_t'(i), vectors[i].exp);
        wait_drained("vector table");

        // tags 0 to 15, each once
        for (int i = 0; i < N_BURST; i++)
        begin
            op = mint_pkg::op_t'($random(seed));
            a  = $random(seed);
            b  = $random(seed);
            send_req($sformatf("burst_%0d", i), op, a, b, mint_pkg::tag_t'(i),
                     ref_result(op, a, b));
        end
        wait_drained("random burst");

        @(negedge clk);
        hold_credits = 1'b1;
        base_rsp   = rsp_count;
        base_pulse = credit_pulses;
        base_sent  = sent;
        for (int i = 0; i < QUEUE_DEPTH + RSP_CREDITS; i++)
        begin
            op = mint_pkg::op_t'($random(seed));
            a  = $random(seed);
            b  = $random(seed);
            send_req($sformatf("held_%0d", i), op, a, b, mint_pkg::tag_t'(i),
                     ref_result(op, a, b));
        end
        @(posedge clk);
        req_valid <= 1'b0;
        waited = 0;
        while (!timed_out && rsp_count - base_rsp < RSP_CREDITS)
        begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("timeout: the responses covered by the initial credits never came");
                errors++;
                timed_out = 1'b1;
            end
        end
        repeat (20) @(posedge clk);     // nothing more may leave
        tests++;
        if (rsp_count - base_rsp != RSP_CREDITS || credit_pulses - base_pulse != RSP_CREDITS)
        begin
            errors++;
            $display("** Error credit_hold: expected %0d responses, actual %0d, credits %0d",
                     RSP_CREDITS, rsp_count - base_rsp, credit_pulses - base_pulse);
        end
        else
            $display("credit_hold  ok");
        @(negedge clk);
        hold_credits = 1'b0;
        wait_drained("held responses");
        tests++;
        if (credit_pulses != sent)
        begin
            errors++;
            $display("** Error credit_total: expected %0d, actual %0d", sent, credit_pulses);
        end
        else
            $display("credit_total ok");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0 && !timed_out)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
